//--- src/bus_pkg.sv
// bus transaction types
// requests as the hosts drive them, responses as they come back,
// and the tagged request that the arbiter hands to the region mapper

package bus_pkg;

	// one data word and one byte address
	typedef logic [31:0] data_t;
	typedef logic [31:0] addr_t;

	// which host a transaction belongs to
	typedef logic host_id_t;

	localparam host_id_t HOST0 = 1'b0;
	localparam host_id_t HOST1 = 1'b1;

	// request as a host drives it, held while valid waits for ready
	typedef struct packed {
		logic  we;
		addr_t addr;
		data_t wdata;
	} host_req_t;

	// single-cycle response to one host
	// rdata is zero for writes
	typedef struct packed {
		logic  valid;
		data_t rdata;
	} host_resp_t;

	// granted request tagged with its host
	typedef struct packed {
		host_req_t req;
		host_id_t  host_id;
	} bus_req_t;

	// cycles from the acceptance edge to the response valid
	localparam int RESP_LATENCY = 2;

endpackage

//--- src/map_pkg.sv
// address map of the shared bus
// bit 31 picks main memory or the MMIO region; the MMIO view splits
// the rest into a device select and a word index

package map_pkg;

	localparam logic REGION_MAIN = 1'b0;
	localparam logic REGION_MMIO = 1'b1;

	typedef logic [3:0] sel_t;
	typedef logic [9:0] mmio_index_t;

	// mmio device selects, bits 15..12
	localparam sel_t SEL_SCRATCH = 4'd0;
	localparam sel_t SEL_GPIO    = 4'd1;

	// word indices inside the gpio block
	localparam mmio_index_t GPIO_LED = 10'd0;
	localparam mmio_index_t GPIO_SW  = 10'd1;

	typedef logic [3:0] led_t;
	typedef logic [1:0] sw_t;

	// main memory sees a plain word index
	typedef struct packed {
		logic        region;
		logic [28:0] word;
		logic [1:0]  byte_off;
	} main_view_t;

	typedef struct packed {
		logic        region;
		logic [14:0] rsvd;
		sel_t        sel;
		mmio_index_t index;
		logic [1:0]  byte_off;
	} mmio_view_t;

	typedef union packed {
		main_view_t main;
		mmio_view_t mmio;
	} map_addr_u;

endpackage

//--- src/bus_arbiter.sv
// round-robin arbiter for the two bus hosts
// grants one valid host per cycle, combinationally, and forwards its
// request tagged with the host id; when both ask, the host that lost
// last time wins

module bus_arbiter (
	input  logic                 clk_main,
	input  logic                 rst_n,

	input  bus_pkg::host_req_t   host0_req,
	input  logic                 host0_valid,
	output logic                 host0_ready,

	input  bus_pkg::host_req_t   host1_req,
	input  logic                 host1_valid,
	output logic                 host1_ready,

	output bus_pkg::bus_req_t    grant_req,
	output logic                 grant_valid
);

	// host granted on the most recent transfer
	bus_pkg::host_id_t last_grant;
	logic              pick1;

	// host1 wins when alone, or when host0 had the last turn
	always_comb begin
		pick1 = 1'b0;
		if (host1_valid) begin
			if (!host0_valid) begin
				pick1 = 1'b1;
			end else if (last_grant == bus_pkg::HOST0) begin
				pick1 = 1'b1;
			end
		end
	end

	assign host0_ready = host0_valid && !pick1;
	assign host1_ready = pick1;

	// the mapper never stalls, so any valid host transfers this cycle
	assign grant_valid = host0_valid || host1_valid;

	always_comb begin
		if (pick1) begin
			grant_req.req     = host1_req;
			grant_req.host_id = bus_pkg::HOST1;
		end else begin
			grant_req.req     = host0_req;
			grant_req.host_id = bus_pkg::HOST0;
		end
	end

	// pretend host1 went last so host0 takes the first contested cycle
	always_ff @(posedge clk_main) begin
		if (!rst_n) begin
			last_grant <= bus_pkg::HOST1;
		end else if (grant_valid) begin
			last_grant <= grant_req.host_id;
		end
	end

endmodule

//--- src/main_ram.sv
// main memory
// word RAM of 2**MEM_AW entries with one registered read port;
// every access answers on the next cycle, writes with zero

module main_ram #(
	parameter int MEM_AW = 10
) (
	input  logic                clk_main,

	input  logic                valid,
	input  logic                we,
	input  logic [MEM_AW-1:0]   index,
	input  bus_pkg::data_t      wdata,
	output bus_pkg::data_t      rdata
);

	localparam int DEPTH = 2 ** MEM_AW;

	bus_pkg::data_t mem [DEPTH];

	always_ff @(posedge clk_main) begin
		if (valid && we) begin
			mem[index] <= wdata;
		end
	end

	// read word or zero on writes and idle cycles
	always_ff @(posedge clk_main) begin
		if (valid && !we) begin
			rdata <= mem[index];
		end else begin
			rdata <= '0;
		end
	end

endmodule

//--- src/mmio_block.sv
// MMIO region
// scratch RAM at select 0 and a small GPIO block at select 1,
// LED register and switch input, behind one registered read port;
// unmapped words read zero and drop writes

module mmio_block #(
	parameter int SCRATCH_AW = 6
) (
	input  logic                 clk_main,
	input  logic                 rst_n,

	input  logic                 valid,
	input  logic                 we,
	input  map_pkg::map_addr_u   addr,
	input  bus_pkg::data_t       wdata,
	output bus_pkg::data_t       rdata,

	input  map_pkg::sw_t         sw,
	output map_pkg::led_t        led
);

	localparam int SCRATCH_DEPTH = 2 ** SCRATCH_AW;

	map_pkg::sel_t         sel;
	map_pkg::mmio_index_t  index;
	logic [SCRATCH_AW-1:0] scratch_index;
	logic                  scratch_hit;
	logic                  led_hit;
	logic                  sw_hit;

	bus_pkg::data_t scratch_mem [SCRATCH_DEPTH];

	assign sel           = addr.mmio.sel;
	assign index         = addr.mmio.index;
	assign scratch_index = index[SCRATCH_AW-1:0];

	// scratch only covers the low part of the index range
	assign scratch_hit = (sel == map_pkg::SEL_SCRATCH) && ((index >> SCRATCH_AW) == '0);
	assign led_hit     = (sel == map_pkg::SEL_GPIO) && (index == map_pkg::GPIO_LED);
	assign sw_hit      = (sel == map_pkg::SEL_GPIO) && (index == map_pkg::GPIO_SW);

	always_ff @(posedge clk_main) begin
		if (valid && we && scratch_hit) begin
			scratch_mem[scratch_index] <= wdata;
		end
	end

	// led pins take the low nibble of the written word
	always_ff @(posedge clk_main) begin
		if (!rst_n) begin
			led <= '0;
		end else if (valid && we && led_hit) begin
			led <= wdata[3:0];
		end
	end

	// switch word takes the pins as they are at the acceptance edge
	always_ff @(posedge clk_main) begin
		rdata <= '0;
		if (valid && !we) begin
			if (scratch_hit) begin
				rdata <= scratch_mem[scratch_index];
			end else if (led_hit) begin
				rdata <= bus_pkg::data_t'(led);
			end else if (sw_hit) begin
				rdata <= bus_pkg::data_t'(sw);
			end
		end
	end

endmodule

//--- src/region_mapper.sv
// region mapper
// sends each granted request to main memory or the MMIO block by
// address bit 31, remembers host and region for the cycle the region
// needs, then loads the answer into that host's response register

module region_mapper #(
	parameter int MEM_AW = 10
) (
	input  logic                 clk_main,
	input  logic                 rst_n,

	input  bus_pkg::bus_req_t    grant_req,
	input  logic                 grant_valid,

	output logic                 ram_valid,
	output logic                 ram_we,
	output logic [MEM_AW-1:0]    ram_index,
	output bus_pkg::data_t       ram_wdata,
	input  bus_pkg::data_t       ram_rdata,

	output logic                 mmio_valid,
	output logic                 mmio_we,
	output map_pkg::map_addr_u   mmio_addr,
	output bus_pkg::data_t       mmio_wdata,
	input  bus_pkg::data_t       mmio_rdata,

	output bus_pkg::host_resp_t  host0_resp,
	output bus_pkg::host_resp_t  host1_resp
);

	// request waiting on its region's registered read
	typedef struct packed {
		logic              valid;
		bus_pkg::host_id_t host;
		logic              mmio;
	} flight_t;

	map_pkg::map_addr_u dec;
	flight_t            flight;
	bus_pkg::data_t     resp_data;

	assign dec = grant_req.req.addr;

	// upper word bits beyond MEM_AW alias
	assign ram_valid = grant_valid && (dec.main.region == map_pkg::REGION_MAIN);
	assign ram_we    = grant_req.req.we;
	assign ram_index = dec.main.word[MEM_AW-1:0];
	assign ram_wdata = grant_req.req.wdata;

	assign mmio_valid = grant_valid && (dec.main.region == map_pkg::REGION_MMIO);
	assign mmio_we    = grant_req.req.we;
	assign mmio_addr  = dec;
	assign mmio_wdata = grant_req.req.wdata;

	always_ff @(posedge clk_main) begin
		if (!rst_n) begin
			flight.valid <= 1'b0;
		end else begin
			flight.valid <= grant_valid;
		end
		flight.host <= grant_req.host_id;
		flight.mmio <= (dec.main.region == map_pkg::REGION_MMIO);
	end

	assign resp_data = flight.mmio ? mmio_rdata : ram_rdata;

	always_ff @(posedge clk_main) begin
		if (!rst_n) begin
			host0_resp.valid <= 1'b0;
			host1_resp.valid <= 1'b0;
		end else begin
			host0_resp.valid <= flight.valid && (flight.host == bus_pkg::HOST0);
			host1_resp.valid <= flight.valid && (flight.host == bus_pkg::HOST1);
		end
		host0_resp.rdata <= resp_data;
		host1_resp.rdata <= resp_data;
	end

endmodule

//--- src/soc_bus_top.sv
// memory path of the SoC
// two hosts share one bus through a round-robin arbiter; the region
// mapper splits traffic between main RAM and the MMIO block

module soc_bus_top #(
	parameter int MEM_AW     = 10,
	parameter int SCRATCH_AW = 6
) (
	input  logic                 clk_main,
	input  logic                 rst_n,

	input  bus_pkg::host_req_t   host0_req,
	input  logic                 host0_valid,
	output logic                 host0_ready,
	output bus_pkg::host_resp_t  host0_resp,

	input  bus_pkg::host_req_t   host1_req,
	input  logic                 host1_valid,
	output logic                 host1_ready,
	output bus_pkg::host_resp_t  host1_resp,

	input  map_pkg::sw_t         sw,
	output map_pkg::led_t        led
);

	bus_pkg::bus_req_t  grant_req;
	logic               grant_valid;

	logic               ram_valid;
	logic               ram_we;
	logic [MEM_AW-1:0]  ram_index;
	bus_pkg::data_t     ram_wdata;
	bus_pkg::data_t     ram_rdata;

	logic               mmio_valid;
	logic               mmio_we;
	map_pkg::map_addr_u mmio_addr;
	bus_pkg::data_t     mmio_wdata;
	bus_pkg::data_t     mmio_rdata;

	bus_arbiter u_arbiter (
		.clk_main    (clk_main),
		.rst_n       (rst_n),
		.host0_req   (host0_req),
		.host0_valid (host0_valid),
		.host0_ready (host0_ready),
		.host1_req   (host1_req),
		.host1_valid (host1_valid),
		.host1_ready (host1_ready),
		.grant_req   (grant_req),
		.grant_valid (grant_valid)
	);

	region_mapper #(
		.MEM_AW (MEM_AW)
	) u_mapper (
		.clk_main    (clk_main),
		.rst_n       (rst_n),
		.grant_req   (grant_req),
		.grant_valid (grant_valid),
		.ram_valid   (ram_valid),
		.ram_we      (ram_we),
		.ram_index   (ram_index),
		.ram_wdata   (ram_wdata),
		.ram_rdata   (ram_rdata),
		.mmio_valid  (mmio_valid),
		.mmio_we     (mmio_we),
		.mmio_addr   (mmio_addr),
		.mmio_wdata  (mmio_wdata),
		.mmio_rdata  (mmio_rdata),
		.host0_resp  (host0_resp),
		.host1_resp  (host1_resp)
	);

	main_ram #(
		.MEM_AW (MEM_AW)
	) u_main_ram (
		.clk_main (clk_main),
		.valid    (ram_valid),
		.we       (ram_we),
		.index    (ram_index),
		.wdata    (ram_wdata),
		.rdata    (ram_rdata)
	);

	mmio_block #(
		.SCRATCH_AW (SCRATCH_AW)
	) u_mmio (
		.clk_main (clk_main),
		.rst_n    (rst_n),
		.valid    (mmio_valid),
		.we       (mmio_we),
		.addr     (mmio_addr),
		.wdata    (mmio_wdata),
		.rdata    (mmio_rdata),
		.sw       (sw),
		.led      (led)
	);

endmodule

//--- tests/soc_bus_checker.sv
// handshake and latency checker for the SoC memory path
// bound to soc_bus_top; watches grants and response timing

module soc_bus_checker (
	input logic                clk_main,
	input logic                rst_n,
	input logic                host0_valid,
	input logic                host0_ready,
	input logic                host1_valid,
	input logic                host1_ready,
	input bus_pkg::host_resp_t host0_resp,
	input bus_pkg::host_resp_t host1_resp
);

	localparam int LAT = bus_pkg::RESP_LATENCY;

	single_grant: assert property (@(posedge clk_main) disable iff (!rst_n)
		!(host0_ready && host1_ready))
		else $error("both req_ready high in one cycle");

	ready_needs_valid: assert property (@(posedge clk_main) disable iff (!rst_n)
		(!host0_ready || host0_valid) && (!host1_ready || host1_valid))
		else $error("req_ready high without req_valid");

	single_resp: assert property (@(posedge clk_main) disable iff (!rst_n)
		!(host0_resp.valid && host1_resp.valid))
		else $error("both response valids high in one cycle");

	// response valid exactly when an acceptance lies LAT edges back
	host0_latency: assert property (@(posedge clk_main) disable iff (!rst_n)
		host0_resp.valid == $past(host0_valid && host0_ready, LAT))
		else $error("host0 response not at fixed latency");

	host1_latency: assert property (@(posedge clk_main) disable iff (!rst_n)
		host1_resp.valid == $past(host1_valid && host1_ready, LAT))
		else $error("host1 response not at fixed latency");

endmodule

//--- tests/soc_bus_tb.sv
// testbench for the SoC memory path
// two host drivers, a reference model of the address map, and a
// compare process for responses, arbitration and the led pins

module soc_bus_tb;

	localparam int MEM_AW     = 10;
	localparam int SCRATCH_AW = 6;
	localparam int N_MAIN     = 12;
	localparam int N_SCR      = 8;
	// main memory on both hosts, then scratch, unmapped and gpio on host1
	localparam int TXN_TOTAL       = 4 * N_MAIN + 2 * N_SCR + 14;
	localparam int WATCHDOG_CYCLES = TXN_TOTAL * 20 + 100;

	typedef struct packed {
		bus_pkg::data_t rdata;
		int             edge_n;
	} expect_t;

	logic                clk_main = 1'b0;
	logic                rst_n;
	bus_pkg::host_req_t  host0_req, host1_req;
	logic                host0_valid, host0_ready, host1_valid, host1_ready;
	bus_pkg::host_resp_t host0_resp, host1_resp;
	map_pkg::sw_t        sw;
	map_pkg::led_t       led;

	bus_pkg::data_t    main_model [2 ** MEM_AW];
	bus_pkg::data_t    scratch_model [2 ** SCRATCH_AW];
	map_pkg::led_t     led_model;
	map_pkg::led_t     led_expect;
	expect_t           exp_q0 [$];
	expect_t           exp_q1 [$];
	bus_pkg::host_id_t prefer;
	bus_pkg::host_id_t win;
	int                cycle_n = 0;
	int                errors = 0;
	int                checks = 0;
	int                pending;

	always #5 clk_main = ~clk_main;

	always @(posedge clk_main) begin
		cycle_n <= cycle_n + 1;
	end

	soc_bus_top #(
		.MEM_AW     (MEM_AW),
		.SCRATCH_AW (SCRATCH_AW)
	) UUT (
		.clk_main    (clk_main),
		.rst_n       (rst_n),
		.host0_req   (host0_req),
		.host0_valid (host0_valid),
		.host0_ready (host0_ready),
		.host0_resp  (host0_resp),
		.host1_req   (host1_req),
		.host1_valid (host1_valid),
		.host1_ready (host1_ready),
		.host1_resp  (host1_resp),
		.sw          (sw),
		.led         (led)
	);

	bind soc_bus_top soc_bus_checker u_checker (.*);

	// 1 scratch word, 2 led, 3 switch, 0 unmapped
	function automatic int mmio_kind(input bus_pkg::addr_t a);
		int kind;
		kind = 0;
		if (a[15:12] == map_pkg::SEL_SCRATCH && int'(a[11:2]) < 2 ** SCRATCH_AW) begin
			kind = 1;
		end else if (a[15:12] == map_pkg::SEL_GPIO && a[11:2] == map_pkg::GPIO_LED) begin
			kind = 2;
		end else if (a[15:12] == map_pkg::SEL_GPIO && a[11:2] == map_pkg::GPIO_SW) begin
			kind = 3;
		end
		return kind;
	endfunction

	// reference model of the word the bus returns for this request
	function automatic bus_pkg::data_t expect_rdata(input bus_pkg::host_req_t r);
		bus_pkg::data_t d;
		d = '0;
		if (!r.we && !r.addr[31]) begin
			d = main_model[r.addr[MEM_AW+1:2]];
		end else if (!r.we) begin
			case (mmio_kind(r.addr))
				1: d = scratch_model[r.addr[SCRATCH_AW+1:2]];
				2: d = bus_pkg::data_t'(led_model);
				3: d = bus_pkg::data_t'(sw);
				default: d = '0;
			endcase
		end
		return d;
	endfunction

	function automatic void apply_write(input bus_pkg::host_req_t r);
		if (r.we && !r.addr[31]) begin
			main_model[r.addr[MEM_AW+1:2]] = r.wdata;
		end else if (r.we && mmio_kind(r.addr) == 1) begin
			scratch_model[r.addr[SCRATCH_AW+1:2]] = r.wdata;
		end else if (r.we && mmio_kind(r.addr) == 2) begin
			led_model = r.wdata[3:0];
		end
	endfunction

	task automatic note_accept(input bus_pkg::host_id_t h, input bus_pkg::host_req_t r);
		expect_t e;
		e.rdata  = expect_rdata(r);
		e.edge_n = cycle_n + bus_pkg::RESP_LATENCY;
		if (h == bus_pkg::HOST0) begin
			exp_q0.push_back(e);
		end else begin
			exp_q1.push_back(e);
		end
		apply_write(r);
		led_expect <= led_model;
	endtask

	task automatic check_data(input string name, input bus_pkg::data_t got,
			input bus_pkg::data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_led(input string name, input map_pkg::led_t got,
			input map_pkg::led_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_grant(input string name, input bus_pkg::host_id_t got,
			input bus_pkg::host_id_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s got host%0d expected host%0d", $time, name, got, exp);
		end
	endtask

	task automatic take_resp(input bus_pkg::host_id_t h, input bus_pkg::data_t got);
		expect_t e;
		int      n;
		n = (h == bus_pkg::HOST0) ? exp_q0.size() : exp_q1.size();
		if (n == 0) begin
			errors++;
			$display("host%0d got a response at %0t with no request outstanding", h, $time);
		end else begin
			if (h == bus_pkg::HOST0) begin
				e = exp_q0.pop_front();
			end else begin
				e = exp_q1.pop_front();
			end
			check_data($sformatf("host%0d_resp.rdata", h), got, e.rdata);
			checks++;
			if (cycle_n != e.edge_n) begin
				errors++;
				$display("** Error at %0t: host%0d_resp.valid edge got %0d expected %0d",
					$time, h, cycle_n, e.edge_n);
			end
		end
	endtask

	// acceptances feed the model
	always @(posedge clk_main) begin
		if (!rst_n) begin
			led_model = '0;
			led_expect <= '0;
		end else if (host0_valid && host0_ready) begin
			note_accept(bus_pkg::HOST0, host0_req);
		end else if (host1_valid && host1_ready) begin
			note_accept(bus_pkg::HOST1, host1_req);
		end
	end

	// compare process
	always @(posedge clk_main) begin
		if (!rst_n) begin
			prefer = bus_pkg::HOST0;
		end else begin
			check_led("led", led, led_expect);
			if (host0_valid || host1_valid) begin
				if (host0_ready == host1_ready) begin
					errors++;
					$display("arbiter did not grant exactly one host at %0t", $time);
				end
				if (host0_valid && host1_valid) begin
					win = prefer;
				end else begin
					win = host1_valid ? bus_pkg::HOST1 : bus_pkg::HOST0;
				end
				check_grant("req_ready", host1_ready ? bus_pkg::HOST1 : bus_pkg::HOST0, win);
				prefer = (win == bus_pkg::HOST0) ? bus_pkg::HOST1 : bus_pkg::HOST0;
			end
			if (host0_resp.valid) begin
				take_resp(bus_pkg::HOST0, host0_resp.rdata);
			end
			if (host1_resp.valid) begin
				take_resp(bus_pkg::HOST1, host1_resp.rdata);
			end
		end
	end

	// called just after a rising edge, returns at the acceptance edge
	task automatic send(input bus_pkg::host_id_t h, input logic we, input bus_pkg::addr_t a,
			input bus_pkg::data_t d);
		bus_pkg::host_req_t r;
		r.we    = we;
		r.addr  = a;
		r.wdata = d;
		if (h == bus_pkg::HOST0) begin
			host0_req   <= r;
			host0_valid <= 1'b1;
		end else begin
			host1_req   <= r;
			host1_valid <= 1'b1;
		end
		@(posedge clk_main);
		while (!((h == bus_pkg::HOST0) ? host0_ready : host1_ready)) begin
			@(posedge clk_main);
		end
	endtask

	task automatic stop_host(input bus_pkg::host_id_t h);
		if (h == bus_pkg::HOST0) begin
			host0_valid <= 1'b0;
		end else begin
			host1_valid <= 1'b0;
		end
	endtask

	// random upper bits, which alias onto the same word
	function automatic bus_pkg::addr_t main_addr(input logic [MEM_AW-1:0] idx);
		bus_pkg::addr_t a;
		a = $urandom;
		a[31] = map_pkg::REGION_MAIN;
		a[MEM_AW+1:2] = idx;
		a[1:0] = 2'b00;
		return a;
	endfunction

	function automatic bus_pkg::addr_t mmio_addr(input map_pkg::sel_t sel,
			input map_pkg::mmio_index_t index);
		return {map_pkg::REGION_MMIO, 15'd0, sel, index, 2'b00};
	endfunction

	task automatic main_traffic(input bus_pkg::host_id_t h);
		logic [MEM_AW-1:0] idx [N_MAIN];
		int                i;
		for (i = 0; i < N_MAIN; i++) begin
			idx[i] = MEM_AW'($urandom);
			send(h, 1'b1, main_addr(idx[i]), $urandom);
		end
		for (i = 0; i < N_MAIN; i++) begin
			send(h, 1'b0, main_addr(idx[i]), '0);
		end
		stop_host(h);
	endtask

	// host1 alone, so requests go back to back
	task automatic mmio_traffic;
		map_pkg::mmio_index_t idx [N_SCR];
		int                   i;
		for (i = 0; i < N_SCR; i++) begin
			idx[i] = map_pkg::mmio_index_t'($urandom % (2 ** SCRATCH_AW));
			send(bus_pkg::HOST1, 1'b1, mmio_addr(map_pkg::SEL_SCRATCH, idx[i]), $urandom);
		end
		// past the scratch words, unused select, unused gpio word
		send(bus_pkg::HOST1, 1'b1, mmio_addr(map_pkg::SEL_SCRATCH, 10'(2 ** SCRATCH_AW + 3)),
			32'hdead_beef);
		send(bus_pkg::HOST1, 1'b1, mmio_addr(4'd7, 10'd5), 32'h0bad_f00d);
		send(bus_pkg::HOST1, 1'b1, mmio_addr(map_pkg::SEL_GPIO, 10'd9), 32'h1234_5678);
		for (i = 0; i < N_SCR; i++) begin
			send(bus_pkg::HOST1, 1'b0, mmio_addr(map_pkg::SEL_SCRATCH, idx[i]), '0);
		end
		send(bus_pkg::HOST1, 1'b0, mmio_addr(map_pkg::SEL_SCRATCH, 10'(2 ** SCRATCH_AW + 3)), '0);
		send(bus_pkg::HOST1, 1'b0, mmio_addr(4'd7, 10'd5), '0);
		send(bus_pkg::HOST1, 1'b0, mmio_addr(map_pkg::SEL_GPIO, 10'd9), '0);
		send(bus_pkg::HOST1, 1'b1, mmio_addr(map_pkg::SEL_GPIO, map_pkg::GPIO_LED), 32'h1234_56a5);
		send(bus_pkg::HOST1, 1'b0, mmio_addr(map_pkg::SEL_GPIO, map_pkg::GPIO_LED), '0);
		sw <= 2'b10;
		send(bus_pkg::HOST1, 1'b0, mmio_addr(map_pkg::SEL_GPIO, map_pkg::GPIO_SW), '0);
		send(bus_pkg::HOST1, 1'b1, mmio_addr(map_pkg::SEL_GPIO, map_pkg::GPIO_SW), 32'hffff_ffff);
		send(bus_pkg::HOST1, 1'b0, mmio_addr(map_pkg::SEL_GPIO, map_pkg::GPIO_SW), '0);
		sw <= 2'b01;
		send(bus_pkg::HOST1, 1'b0, mmio_addr(map_pkg::SEL_GPIO, map_pkg::GPIO_SW), '0);
		send(bus_pkg::HOST1, 1'b1, mmio_addr(map_pkg::SEL_GPIO, map_pkg::GPIO_LED), 32'h0000_000c);
		send(bus_pkg::HOST1, 1'b0, mmio_addr(map_pkg::SEL_GPIO, map_pkg::GPIO_LED), '0);
		stop_host(bus_pkg::HOST1);
	endtask

	initial begin
		void'($urandom(32'h3aa6ffcc));
		rst_n       <= 1'b0;
		host0_req   <= '0;
		host0_valid <= 1'b0;
		host1_req   <= '0;
		host1_valid <= 1'b0;
		sw          <= '0;
		repeat (2) @(posedge clk_main);
		rst_n <= 1'b1;
		// both hosts valid right after reset so grants alternate
		fork
			main_traffic(bus_pkg::HOST0);
			main_traffic(bus_pkg::HOST1);
		join
		mmio_traffic();
		repeat (bus_pkg::RESP_LATENCY + 2) @(posedge clk_main);
		pending = exp_q0.size() + exp_q1.size();
		if (pending != 0) begin
			$display("%0d accepted requests never got a response", pending);
		end
		$display("checks: %0d  errors: %0d  missing responses: %0d", checks, errors, pending);
		if (errors == 0 && pending == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_main);
		$display("watchdog expired after %0d cycles, the bus stopped moving", WATCHDOG_CYCLES);
		$display("checks: %0d  errors: %0d", checks, errors);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- project.f
src/bus_pkg.sv
src/map_pkg.sv
src/bus_arbiter.sv
src/main_ram.sv
src/mmio_block.sv
src/region_mapper.sv
src/soc_bus_top.sv
tests/soc_bus_checker.sv
tests/soc_bus_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the soc bus testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module soc_bus_tb -f project.f

status=0
output=$(./obj_dir/Vsoc_bus_tb) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -q "All tests passed!" <<< "$output"; then
	exit 0
fi
exit 1
